//--- common/csr_defs.svh
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Data width of every machine CSR
`define CSR_XLEN            32

// Writable bits per register
`define CSR_WMASK_MSTATUS   32'h007E19AA
`define CSR_WMASK_MISA      32'h3C000000
`define CSR_WMASK_MIE       32'h00000888
`define CSR_WMASK_MTVEC     32'hFFFFFFFC
`define CSR_WMASK_MEPC      32'hFFFFFFFC
`define CSR_WMASK_FULL      32'hFFFFFFFF
`define CSR_WMASK_NONE      32'h00000000

// RV32I, MXL = 1
`define CSR_MISA_RESET      32'h40000100

// mstatus fields
`define CSR_MSTATUS_MIE     3
`define CSR_MSTATUS_MPIE    7
`define CSR_MSTATUS_MPP_LO  11

// Instruction size, used for the return address after a trap
`define CSR_INSTR_BYTES     32'd4

`endif

//--- common/csr_pkg.sv
`default_nettype none

`include "csr_defs.svh"

package csr_pkg;

    // CSR instruction flavour
    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_e;

    // Machine CSR addresses, implemented and read-as-zero ones
    typedef enum logic [11:0] {
        CSR_MSTATUS    = 12'h300,
        CSR_MISA       = 12'h301,
        CSR_MIE        = 12'h304,
        CSR_MTVEC      = 12'h305,
        CSR_MSCRATCH   = 12'h340,
        CSR_MEPC       = 12'h341,
        CSR_MCAUSE     = 12'h342,
        CSR_MTVAL      = 12'h343,
        CSR_MIP        = 12'h344,
        CSR_MVENDORID  = 12'hF11,
        CSR_MARCHID    = 12'hF12,
        CSR_MIMPID     = 12'hF13,
        CSR_MHARTID    = 12'hF14,
        CSR_MCONFIGPTR = 12'hF15
    } csr_addr_e;

    // Standard synchronous exception codes
    typedef enum logic [31:0] {
        EXC_INSTR_MISALIGNED    = 32'd0,
        EXC_INSTR_ACCESS_FAULT  = 32'd1,
        EXC_ILLEGAL_INSTRUCTION = 32'd2,
        EXC_BREAKPOINT          = 32'd3,
        EXC_LOAD_MISALIGNED     = 32'd4,
        EXC_LOAD_ACCESS_FAULT   = 32'd5,
        EXC_STORE_MISALIGNED    = 32'd6,
        EXC_STORE_ACCESS_FAULT  = 32'd7,
        EXC_ECALL_U             = 32'd8,
        EXC_ECALL_M             = 32'd11
    } exc_code_e;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_e;

    // One of these per cycle, picked by trap_ctrl
    typedef enum logic [1:0] {
        ACT_IDLE  = 2'd0,
        ACT_TRAP  = 2'd1,
        ACT_MRET  = 2'd2,
        ACT_WRITE = 2'd3
    } csr_action_e;

    typedef struct packed {
        logic                 rd_en;
        logic                 wr_en;
        logic                 killed;
        csr_op_e              op;
        logic [11:0]          addr;
        logic [`CSR_XLEN-1:0] data;
    } csr_req_t;

    typedef struct packed {
        logic                 raise_exception;
        logic                 machine_return;
        exc_code_e            cause;
        logic [`CSR_XLEN-1:0] pc;
        logic [`CSR_XLEN-1:0] instruction;
    } trap_req_t;

    // Full machine CSR state as seen by the write path
    typedef struct packed {
        logic [`CSR_XLEN-1:0] mstatus;
        logic [`CSR_XLEN-1:0] misa;
        logic [`CSR_XLEN-1:0] mie;
        logic [`CSR_XLEN-1:0] mtvec;
        logic [`CSR_XLEN-1:0] mscratch;
        logic [`CSR_XLEN-1:0] mepc;
        logic [`CSR_XLEN-1:0] mcause;
        logic [`CSR_XLEN-1:0] mtval;
        logic [`CSR_XLEN-1:0] mip;
    } csr_regs_t;

endpackage

`default_nettype wire

//--- verilog/csr_write_path.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_defs.svh"

module csr_write_path (
    input  logic [11:0]          addr,
    input  csr_pkg::csr_op_e     op,
    input  logic [`CSR_XLEN-1:0] data,
    input  csr_pkg::csr_regs_t   regs,
    output logic [`CSR_XLEN-1:0] wdata
);
    import csr_pkg::*;

    logic [`CSR_XLEN-1:0] current_val;
    logic [`CSR_XLEN-1:0] wmask;

    // Address decode to current value and writable bits
    always_comb begin
        current_val = '0;
        wmask       = `CSR_WMASK_NONE;
        case (addr)
            CSR_MSTATUS: begin
                current_val = regs.mstatus;
                wmask       = `CSR_WMASK_MSTATUS;
            end
            CSR_MISA: begin
                current_val = regs.misa;
                wmask       = `CSR_WMASK_MISA;
            end
            CSR_MIE: begin
                current_val = regs.mie;
                wmask       = `CSR_WMASK_MIE;
            end
            CSR_MTVEC: begin
                current_val = regs.mtvec;
                wmask       = `CSR_WMASK_MTVEC;
            end
            CSR_MSCRATCH: begin
                current_val = regs.mscratch;
                wmask       = `CSR_WMASK_FULL;
            end
            CSR_MEPC: begin
                current_val = regs.mepc;
                wmask       = `CSR_WMASK_MEPC;
            end
            CSR_MCAUSE: begin
                current_val = regs.mcause;
                wmask       = `CSR_WMASK_FULL;
            end
            CSR_MTVAL: begin
                current_val = regs.mtval;
                wmask       = `CSR_WMASK_FULL;
            end
            // mip has no writable bits, no interrupt sources here
            CSR_MIP: begin
                current_val = regs.mip;
                wmask       = `CSR_WMASK_NONE;
            end
            default: begin
                current_val = '0;
                wmask       = `CSR_WMASK_NONE;
            end
        endcase
    end

    // Write, set or clear, all under the mask
    always_comb begin
        case (op)
            CSR_WRITE: wdata = data & wmask;
            CSR_SET:   wdata = (current_val | data) & wmask;
            CSR_CLEAR: wdata = (current_val & ~data) & wmask;
            default:   wdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/trap_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module trap_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_pkg::csr_req_t    csr_req,
    input  csr_pkg::trap_req_t   trap_req,
    input  csr_pkg::priv_e       mpp,
    output csr_pkg::csr_action_e action,
    output csr_pkg::priv_e       prev_priv,
    output csr_pkg::priv_e       priv
);
    import csr_pkg::*;

    priv_e priv_q;
    priv_e priv_d;
    priv_e ret_priv;

    // One action per cycle, return first, then trap, then CSR write
    always_comb begin
        if (!reset) begin
            action = ACT_IDLE;
        end else if (trap_req.machine_return) begin
            action = ACT_MRET;
        end else if (trap_req.raise_exception) begin
            action = ACT_TRAP;
        end else if (csr_req.wr_en && !csr_req.killed) begin
            action = ACT_WRITE;
        end else begin
            action = ACT_IDLE;
        end
    end

    // MPP is writable with 01/10 as well; only U is honoured, the rest go back to M
    assign ret_priv = (mpp == PRIV_U) ? PRIV_U : PRIV_M;

    always_comb begin
        case (action)
            ACT_TRAP: priv_d = PRIV_M;
            ACT_MRET: priv_d = ret_priv;
            default:  priv_d = priv_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            priv_q <= PRIV_M;
        end else begin
            priv_q <= priv_d;
        end
    end

    // Level before the trap, saved into MPP by the bank
    assign prev_priv = priv_q;
    assign priv      = priv_q;

    // Only U and M exist, whatever the bank hands back as MPP
    a_priv_legal: assert property (
        @(posedge clk) disable iff (!reset)
        priv_q inside {PRIV_U, PRIV_M}
    );

endmodule

`default_nettype wire

//--- csr_bank/csr_bank.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_defs.svh"

module csr_bank (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_pkg::csr_action_e action,
    input  csr_pkg::priv_e       prev_priv,
    input  csr_pkg::csr_req_t    csr_req,
    input  csr_pkg::trap_req_t   trap_req,
    input  logic [`CSR_XLEN-1:0] wdata,
    output csr_pkg::csr_regs_t   regs,
    output csr_pkg::priv_e       mpp,
    output logic [`CSR_XLEN-1:0] rdata,
    output logic [`CSR_XLEN-1:0] mtvec,
    output logic [`CSR_XLEN-1:0] mepc
);
    import csr_pkg::*;

    csr_regs_t            regs_q;
    logic [`CSR_XLEN-1:0] trap_epc;
    logic [`CSR_XLEN-1:0] trap_tval;

    // ECALL from M returns to the ecall itself, everything else skips ahead.
    // IALIGN is 32, so the low bits of mepc are forced to zero
    assign trap_epc = ((trap_req.cause == EXC_ECALL_M) ? trap_req.pc
                                                       : trap_req.pc + `CSR_INSTR_BYTES)
                      & `CSR_WMASK_MEPC;

    // Faulting instruction for illegal ops, pc otherwise
    assign trap_tval = (trap_req.cause == EXC_ILLEGAL_INSTRUCTION) ? trap_req.instruction
                                                                   : trap_req.pc;

    always_ff @(posedge clk) begin
        if (!reset) begin
            regs_q      <= '0;
            regs_q.misa <= `CSR_MISA_RESET;
        end else begin
            case (action)
                ACT_MRET: begin
                    regs_q.mstatus[`CSR_MSTATUS_MIE] <= regs_q.mstatus[`CSR_MSTATUS_MPIE];
                end
                ACT_TRAP: begin
                    regs_q.mcause                          <= trap_req.cause;
                    regs_q.mstatus[`CSR_MSTATUS_MPP_LO +: 2] <= prev_priv;
                    regs_q.mstatus[`CSR_MSTATUS_MPIE]      <= regs_q.mstatus[`CSR_MSTATUS_MIE];
                    regs_q.mstatus[`CSR_MSTATUS_MIE]       <= 1'b0;
                    regs_q.mepc                            <= trap_epc;
                    regs_q.mtval                           <= trap_tval;
                end
                ACT_WRITE: begin
                    case (csr_req.addr)
                        CSR_MSTATUS:  regs_q.mstatus  <= wdata;
                        CSR_MISA:     regs_q.misa     <= wdata;
                        CSR_MIE:      regs_q.mie      <= wdata;
                        CSR_MTVEC:    regs_q.mtvec    <= wdata;
                        CSR_MSCRATCH: regs_q.mscratch <= wdata;
                        CSR_MEPC:     regs_q.mepc     <= wdata;
                        CSR_MCAUSE:   regs_q.mcause   <= wdata;
                        CSR_MTVAL:    regs_q.mtval    <= wdata;
                        CSR_MIP:      regs_q.mip      <= wdata;
                        default:      ;
                    endcase
                end
                default: ;
            endcase
        end
    end

    // Read port, combinational
    always_comb begin
        rdata = '0;
        if (csr_req.rd_en && !csr_req.killed) begin
            case (csr_req.addr)
                CSR_MSTATUS:    rdata = regs_q.mstatus;
                CSR_MISA:       rdata = regs_q.misa;
                CSR_MIE:        rdata = regs_q.mie;
                CSR_MTVEC:      rdata = regs_q.mtvec;
                CSR_MSCRATCH:   rdata = regs_q.mscratch;
                CSR_MEPC:       rdata = regs_q.mepc;
                CSR_MCAUSE:     rdata = regs_q.mcause;
                CSR_MTVAL:      rdata = regs_q.mtval;
                CSR_MIP:        rdata = regs_q.mip;
                // Identity registers read as zero
                CSR_MVENDORID,
                CSR_MARCHID,
                CSR_MIMPID,
                CSR_MHARTID,
                CSR_MCONFIGPTR: rdata = '0;
                default:        rdata = '0;
            endcase
        end
    end

    assign regs  = regs_q;
    assign mpp   = priv_e'(regs_q.mstatus[`CSR_MSTATUS_MPP_LO +: 2]);
    assign mtvec = regs_q.mtvec;
    assign mepc  = regs_q.mepc;

    // Write masks and trap path together keep both vectors word aligned
    a_vec_aligned: assert property (
        @(posedge clk) disable iff (!reset)
        (regs_q.mtvec[1:0] == 2'b00) && (regs_q.mepc[1:0] == 2'b00)
    );

    // mip is writable only through a zero mask
    a_mip_zero: assert property (
        @(posedge clk) disable iff (!reset)
        regs_q.mip == '0
    );

endmodule

`default_nettype wire

//--- verilog/csr_unit_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_defs.svh"

module csr_unit_top (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_pkg::csr_req_t    csr_req,
    input  csr_pkg::trap_req_t   trap_req,
    output logic [`CSR_XLEN-1:0] rdata,
    output logic [`CSR_XLEN-1:0] mtvec,
    output logic [`CSR_XLEN-1:0] mepc,
    output csr_pkg::priv_e       priv
);
    import csr_pkg::*;

    csr_action_e          action;
    priv_e                prev_priv;
    priv_e                mpp;
    csr_regs_t            regs;
    logic [`CSR_XLEN-1:0] wdata;

    trap_ctrl u_trap_ctrl (
        .clk       (clk),
        .reset     (reset),
        .csr_req   (csr_req),
        .trap_req  (trap_req),
        .mpp       (mpp),
        .action    (action),
        .prev_priv (prev_priv),
        .priv      (priv)
    );

    csr_write_path u_write_path (
        .addr  (csr_req.addr),
        .op    (csr_req.op),
        .data  (csr_req.data),
        .regs  (regs),
        .wdata (wdata)
    );

    csr_bank u_bank (
        .clk       (clk),
        .reset     (reset),
        .action    (action),
        .prev_priv (prev_priv),
        .csr_req   (csr_req),
        .trap_req  (trap_req),
        .wdata     (wdata),
        .regs      (regs),
        .mpp       (mpp),
        .rdata     (rdata),
        .mtvec     (mtvec),
        .mepc      (mepc)
    );

endmodule

`default_nettype wire

//--- sim/csr_model.svh
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// Reference copy of the machine CSR state and privilege level
csr_regs_t model_regs;
priv_e     model_priv;

function automatic logic [31:0] model_mask(input logic [11:0] addr);
    case (addr)
        CSR_MSTATUS:                        return `CSR_WMASK_MSTATUS;
        CSR_MISA:                           return `CSR_WMASK_MISA;
        CSR_MIE:                            return `CSR_WMASK_MIE;
        CSR_MTVEC:                          return `CSR_WMASK_MTVEC;
        CSR_MEPC:                           return `CSR_WMASK_MEPC;
        CSR_MSCRATCH, CSR_MCAUSE, CSR_MTVAL: return `CSR_WMASK_FULL;
        default:                            return 32'h0;
    endcase
endfunction

// Stored value, zero for identity registers and unknown addresses
function automatic logic [31:0] model_read(input logic [11:0] addr);
    case (addr)
        CSR_MSTATUS:  return model_regs.mstatus;
        CSR_MISA:     return model_regs.misa;
        CSR_MIE:      return model_regs.mie;
        CSR_MTVEC:    return model_regs.mtvec;
        CSR_MSCRATCH: return model_regs.mscratch;
        CSR_MEPC:     return model_regs.mepc;
        CSR_MCAUSE:   return model_regs.mcause;
        CSR_MTVAL:    return model_regs.mtval;
        default:      return 32'h0;
    endcase
endfunction

task automatic model_reset();
    model_regs      = '0;
    model_regs.misa = 32'h40000100;
    model_priv      = PRIV_M;
endtask

task automatic model_write(input logic [11:0] addr, input logic [31:0] value);
    case (addr)
        CSR_MSTATUS:  model_regs.mstatus  = value;
        CSR_MISA:     model_regs.misa     = value;
        CSR_MIE:      model_regs.mie      = value;
        CSR_MTVEC:    model_regs.mtvec    = value;
        CSR_MSCRATCH: model_regs.mscratch = value;
        CSR_MEPC:     model_regs.mepc     = value;
        CSR_MCAUSE:   model_regs.mcause   = value;
        CSR_MTVAL:    model_regs.mtval    = value;
        default:      ;
    endcase
endtask

// One clock edge: return beats trap, trap beats a live write
task automatic model_step(input csr_req_t r, input trap_req_t t);
    logic [31:0] ms;
    logic [31:0] cur;
    logic [31:0] nv;
    ms = model_regs.mstatus;
    if (t.machine_return) begin
        ms[3] = ms[7];
        model_regs.mstatus = ms;
        // MPP encodings other than U return to M
        model_priv = (ms[12:11] == 2'b00) ? PRIV_U : PRIV_M;
    end else if (t.raise_exception) begin
        ms[12:11] = model_priv;
        ms[7]     = ms[3];
        ms[3]     = 1'b0;
        model_regs.mstatus = ms;
        model_regs.mcause  = t.cause;
        model_regs.mepc    = ((t.cause == EXC_ECALL_M) ? t.pc : t.pc + 32'd4) & ~32'h3;
        model_regs.mtval   = (t.cause == EXC_ILLEGAL_INSTRUCTION) ? t.instruction : t.pc;
        model_priv         = PRIV_M;
    end else if (r.wr_en && !r.killed) begin
        cur = model_read(r.addr);
        case (r.op)
            CSR_WRITE: nv = r.data;
            CSR_SET:   nv = cur | r.data;
            CSR_CLEAR: nv = cur & ~r.data;
            default:   nv = 32'h0;
        endcase
        model_write(r.addr, nv & model_mask(r.addr));
    end
endtask

`endif

//--- sim/tb_csr_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_defs.svh"

module tb_csr_unit;
    import csr_pkg::*;

    localparam int N_WRITE = 100;
    localparam int N_KILL  = 40;
    localparam int N_TRAP  = 40;
    localparam int N_RET   = 20;
    localparam int N_OTHER = 40;
    localparam int TOTAL_CYCLES = 3 + 9 + 2 * N_WRITE + 2 * N_KILL + 7 * N_TRAP
                                  + 5 * N_RET + 2 * N_OTHER;

    logic        clk;
    logic        reset;
    csr_req_t    csr_req;
    trap_req_t   trap_req;
    logic [31:0] rdata;
    logic [31:0] mtvec;
    logic [31:0] mepc;
    priv_e       priv;
    logic [31:0] lcg_state;
    int          checks_passed;
    int          checks_failed;
    int          test_errors;

    `include "csr_model.svh"

    csr_unit_top uut (
        .clk      (clk),
        .reset    (reset),
        .csr_req  (csr_req),
        .trap_req (trap_req),
        .rdata    (rdata),
        .mtvec    (mtvec),
        .mepc     (mepc),
        .priv     (priv)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #((TOTAL_CYCLES + 50) * 100);
        $display("Watchdog expired at %0t before all tests finished", $time);
        $display("** FAIL **");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // High bits only, the low LCG bits repeat quickly
    function automatic int rand_below(input int n);
        return int'((next_rand() >> 16) % n);
    endfunction

    function automatic logic [11:0] impl_addr(input int i);
        case (i)
            0:       return CSR_MSTATUS;
            1:       return CSR_MISA;
            2:       return CSR_MIE;
            3:       return CSR_MTVEC;
            4:       return CSR_MSCRATCH;
            5:       return CSR_MEPC;
            6:       return CSR_MCAUSE;
            7:       return CSR_MTVAL;
            default: return CSR_MIP;
        endcase
    endfunction

    // Identity registers plus a few addresses nothing decodes
    function automatic logic [11:0] other_addr();
        case (rand_below(8))
            0:       return CSR_MVENDORID;
            1:       return CSR_MARCHID;
            2:       return CSR_MIMPID;
            3:       return CSR_MHARTID;
            4:       return CSR_MCONFIGPTR;
            5:       return 12'h000;
            6:       return 12'h3A0;
            default: return 12'h7C0;
        endcase
    endfunction

    function automatic exc_code_e pick_cause();
        case (rand_below(10))
            0:       return EXC_INSTR_MISALIGNED;
            1:       return EXC_INSTR_ACCESS_FAULT;
            2:       return EXC_ILLEGAL_INSTRUCTION;
            3:       return EXC_BREAKPOINT;
            4:       return EXC_LOAD_MISALIGNED;
            5:       return EXC_LOAD_ACCESS_FAULT;
            6:       return EXC_STORE_MISALIGNED;
            7:       return EXC_STORE_ACCESS_FAULT;
            8:       return EXC_ECALL_U;
            default: return EXC_ECALL_M;
        endcase
    endfunction

    function automatic csr_op_e pick_op();
        case (rand_below(3))
            0:       return CSR_WRITE;
            1:       return CSR_SET;
            default: return CSR_CLEAR;
        endcase
    endfunction

    function automatic csr_req_t make_req(input logic rd, input logic wr, input logic kill,
                                          input csr_op_e op, input logic [11:0] addr,
                                          input logic [31:0] data);
        csr_req_t r;
        r.rd_en  = rd;
        r.wr_en  = wr;
        r.killed = kill;
        r.op     = op;
        r.addr   = addr;
        r.data   = data;
        return r;
    endfunction

    function automatic trap_req_t make_trap(input logic exc, input logic ret);
        trap_req_t t;
        t.raise_exception = exc;
        t.machine_return  = ret;
        t.cause           = pick_cause();
        t.pc              = next_rand();
        t.instruction     = next_rand();
        return t;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) begin
            checks_passed++;
        end else begin
            $display("** Error at %0t: %s expected %h, got %h", $time, what, exp, got);
            checks_failed++;
            test_errors++;
        end
    endtask

    // Drive one request, compare mid-cycle, then advance the model past the edge
    task automatic run_cycle(input csr_req_t r, input trap_req_t t);
        logic [31:0] exp_rdata;
        @(posedge clk);
        #10;
        csr_req  = r;
        trap_req = t;
        #40;
        exp_rdata = (r.rd_en && !r.killed) ? model_read(r.addr) : 32'h0;
        check_value("rdata", exp_rdata, rdata);
        check_value("mtvec", model_regs.mtvec, mtvec);
        check_value("mepc", model_regs.mepc, mepc);
        check_value("mtvec/mepc low bits", 32'h0, {28'h0, mtvec[1:0], mepc[1:0]});
        check_value("priv", {30'h0, model_priv}, {30'h0, priv});
        model_step(r, t);
    endtask

    task automatic read_reg(input logic [11:0] addr);
        run_cycle(make_req(1'b1, 1'b0, 1'b0, CSR_NONE, addr, 32'h0), '0);
    endtask

    task automatic finish_test(input string name);
        $display("Test %s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "failed",
                 test_errors);
        test_errors = 0;
    endtask

    initial begin
        logic [11:0] a;
        logic [31:0] d;
        lcg_state     = 32'd61770;
        checks_passed = 0;
        checks_failed = 0;
        test_errors   = 0;
        reset         = 1'b0;
        csr_req       = '0;
        trap_req      = '0;
        model_reset();
        repeat (3) @(posedge clk);
        #10;
        reset = 1'b1;

        for (int i = 0; i < 9; i++) begin
            a = impl_addr(i);
            read_reg(a);
            check_value("reset value", (a == CSR_MISA) ? 32'h40000100 : 32'h0, rdata);
            check_value("reset priv", {30'h0, PRIV_M}, {30'h0, priv});
        end
        finish_test("reset_values");

        repeat (N_WRITE) begin
            a = impl_addr(rand_below(9));
            run_cycle(make_req(1'b1, 1'b1, 1'b0, pick_op(), a, next_rand()), '0);
            read_reg(a);
        end
        finish_test("masked_writes");

        repeat (N_KILL) begin
            a = impl_addr(rand_below(9));
            d = next_rand();
            run_cycle(make_req(1'b1, d[31], 1'b1, pick_op(), a, next_rand()), '0);
            check_value("killed read", 32'h0, rdata);
            read_reg(a);
        end
        finish_test("killed_requests");

        // Random MPP before the return, so traps come from U and from M
        repeat (N_TRAP) begin
            run_cycle(make_req(1'b0, 1'b1, 1'b0, CSR_WRITE, CSR_MSTATUS, next_rand()), '0);
            run_cycle(make_req(1'b0, 1'b0, 1'b0, CSR_NONE, CSR_MSTATUS, 32'h0),
                      make_trap(1'b0, 1'b1));
            run_cycle(make_req(1'b0, 1'b0, 1'b0, CSR_NONE, CSR_MSTATUS, 32'h0),
                      make_trap(1'b1, 1'b0));
            read_reg(CSR_MCAUSE);
            read_reg(CSR_MEPC);
            read_reg(CSR_MTVAL);
            read_reg(CSR_MSTATUS);
        end
        finish_test("exception_entry");

        repeat (N_RET) begin
            d = next_rand() & ~32'h0000_1800;
            run_cycle(make_req(1'b0, 1'b1, 1'b0, CSR_WRITE, CSR_MSTATUS, d), '0);
            run_cycle(make_req(1'b0, 1'b0, 1'b0, CSR_NONE, CSR_MSTATUS, 32'h0),
                      make_trap(1'b0, 1'b1));
            read_reg(CSR_MSTATUS);
            check_value("priv after return", {30'h0, PRIV_U}, {30'h0, priv});
            check_value("MIE after return", {31'h0, d[7]}, {31'h0, rdata[3]});
            // Return, trap and write all at once, the return must win
            run_cycle(make_req(1'b0, 1'b1, 1'b0, CSR_WRITE, CSR_MSCRATCH, next_rand()),
                      make_trap(1'b1, 1'b1));
            read_reg(CSR_MSCRATCH);
            check_value("priv after priority", {30'h0, PRIV_U}, {30'h0, priv});
        end
        finish_test("machine_return");

        repeat (N_OTHER) begin
            run_cycle(make_req(1'b1, 1'b1, 1'b0, pick_op(), other_addr(), next_rand()), '0);
            check_value("unimplemented read", 32'h0, rdata);
            read_reg(impl_addr(rand_below(9)));
        end
        finish_test("unimplemented_addresses");

        $display("Checks: %0d passed, %0d failed", checks_passed, checks_failed);
        if (checks_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+common
+incdir+sim
common/csr_pkg.sv
verilog/csr_write_path.sv
verilog/trap_ctrl.sv
csr_bank/csr_bank.sv
verilog/csr_unit_top.sv
sim/tb_csr_unit.sv

//--- Makefile
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module csr_unit_top -f build.f

sim:
	verilator --binary --timing --assert --top-module tb_csr_unit -f build.f \
		-Mdir obj_dir -o tb_csr_unit
	./obj_dir/tb_csr_unit | tee $(LOG)
	grep -q '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
